// File: Makefile
TOP = mem_system_tb

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@! grep -q "TEST FAIL" sim.log
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: bank_memory/bank_memory.sv
// four bank interleaved memory
`timescale 1ns/1ps

module bank_memory #(
   parameter int unsigned bank_latency = 2
) (
   input  logic               clk,
   input  logic               reset,
   input  mem_pkg::mem_req_t  req,
   output mem_pkg::mem_resp_t resp,
   output logic               mem_stall,
   output logic               err
);
   import mem_pkg::*;

   localparam int unsigned cnt_w = $clog2(bank_latency + 1);

   word_t banks [num_banks][bank_words];
   logic [cnt_w-1:0] busy_cnt [num_banks];

   // read response pipeline
   logic [bank_latency-1:0] pipe_valid;
   word_sel_t pipe_sel  [bank_latency];
   word_t     pipe_data [bank_latency];

   word_sel_t bank_sel;
   row_t      row;
   logic      req_any;
   logic      accept;

   assign bank_sel  = req.addr[1:0];
   assign row       = req.addr[14:2];
   assign req_any   = req.rd | req.wr;
   assign mem_stall = req_any & (busy_cnt[bank_sel] != '0);
   assign accept    = req_any & ~mem_stall;
   assign err       = req.rd & req.wr;

   initial begin
      for (int b = 0; b < num_banks; b++) begin
         for (int w = 0; w < bank_words; w++) begin
            banks[b][w] = '0;
         end
      end
   end

   always @(posedge clk) begin
      if (accept && req.wr) begin
         banks[bank_sel][row] <= req.data;
      end
   end

   // bank stays busy for the read latency after it takes a request
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int b = 0; b < num_banks; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < num_banks; b++) begin
            if (accept && bank_sel == word_sel_t'(b)) begin
               busy_cnt[b] <= cnt_w'(bank_latency);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pipe_valid <= '0;
      end else begin
         pipe_valid[0] <= accept & req.rd;
         for (int s = 1; s < bank_latency; s++) begin
            pipe_valid[s] <= pipe_valid[s-1];
         end
      end
   end

   always_ff @(posedge clk) begin
      pipe_sel[0]  <= bank_sel;
      pipe_data[0] <= banks[bank_sel][row];
      for (int s = 1; s < bank_latency; s++) begin
         pipe_sel[s]  <= pipe_sel[s-1];
         pipe_data[s] <= pipe_data[s-1];
      end
   end

   assign resp = '{valid:    pipe_valid[bank_latency-1],
                   word_sel: pipe_sel[bank_latency-1],
                   data:     pipe_data[bank_latency-1]};

   // a stalled request waits on the bus until the bank takes it
   assert property (@(posedge clk) disable iff (reset)
      mem_stall |=> (req.rd == $past(req.rd) && req.wr == $past(req.wr)
                     && req.addr == $past(req.addr)));

endmodule

// File: cache/cache_controller.sv
// cache controller FSM
`timescale 1ns/1ps

module cache_controller (
   input  logic                 clk,
   input  logic                 reset,
   input  mem_pkg::addr_t       Addr,
   input  mem_pkg::word_t       DataIn,
   input  logic                 Rd,
   input  logic                 Wr,
   input  mem_pkg::cache_stat_t stat,
   input  mem_pkg::mem_resp_t   resp,
   input  logic                 mem_stall,
   output mem_pkg::cache_cmd_t  cmd,
   output mem_pkg::mem_req_t    req,
   output mem_pkg::word_t       DataOut,
   output logic                 Done,
   output logic                 Stall,
   output logic                 CacheHit,
   output logic                 err
);
   import mem_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_compare,
      st_writeback,
      st_fill_issue,
      st_fill_wait,
      st_done
   } ctrl_state_t;

   localparam word_sel_t last_word = word_sel_t'(words_per_line - 1);

   ctrl_state_t state;
   ctrl_state_t next_state;

   // latched request
   tag_t      cur_tag;
   index_t    cur_index;
   word_sel_t cur_sel;
   word_t     cur_data;
   logic      cur_wr;

   // word counter for write-back and fill issue
   word_sel_t cnt;
   logic      miss_seen;

   logic accept;
   logic bad_req;
   logic victim_dirty;
   logic mem_take;
   logic fill_word;
   logic last_fill;

   assign accept       = (state == st_idle) & (Rd | Wr);
   assign bad_req      = (Rd & Wr) | Addr[0];
   assign victim_dirty = stat.valid & stat.dirty;
   assign mem_take     = (req.rd | req.wr) & ~mem_stall;
   assign fill_word    = resp.valid & ((state == st_fill_issue) | (state == st_fill_wait));
   assign last_fill    = fill_word & (resp.word_sel == last_word);

   always_comb begin
      next_state = state;
      case (state)
         st_idle: begin
            if (accept) begin
               next_state = bad_req ? st_done : st_compare;
            end
         end
         st_compare: begin
            if (stat.hit) begin
               next_state = st_idle;
            end else begin
               next_state = victim_dirty ? st_writeback : st_fill_issue;
            end
         end
         st_writeback: begin
            if (mem_take && cnt == last_word) begin
               next_state = st_fill_issue;
            end
         end
         st_fill_issue: begin
            if (mem_take && cnt == last_word) begin
               next_state = st_fill_wait;
            end
         end
         st_fill_wait: begin
            if (last_fill) begin
               next_state = st_compare;
            end
         end
         default: next_state = st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= st_idle;
         cnt       <= '0;
         miss_seen <= 1'b0;
      end else begin
         state <= next_state;
         if (accept) begin
            cnt       <= '0;
            miss_seen <= 1'b0;
         end else begin
            if (mem_take) begin
               cnt <= cnt + 1'b1;
            end
            if (state == st_compare && !stat.hit) begin
               miss_seen <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_tag   <= Addr[15:11];
         cur_index <= Addr[10:3];
         cur_sel   <= Addr[2:1];
         cur_data  <= DataIn;
         cur_wr    <= Wr;
      end
   end

   // cache side
   always_comb begin
      cmd.enable   = 1'b0;
      cmd.comp     = 1'b0;
      cmd.write    = 1'b0;
      cmd.valid_in = 1'b0;
      cmd.index    = cur_index;
      cmd.tag      = cur_tag;
      cmd.word_sel = cur_sel;
      cmd.data     = cur_data;
      case (state)
         st_compare: begin
            cmd.enable = 1'b1;
            cmd.comp   = 1'b1;
            cmd.write  = cur_wr;
         end
         st_writeback: begin
            cmd.enable   = 1'b1;
            cmd.word_sel = cnt;
         end
         default: begin
            // fill words go wherever the bank says they belong
            if (fill_word) begin
               cmd.enable   = 1'b1;
               cmd.write    = 1'b1;
               cmd.word_sel = resp.word_sel;
               cmd.data     = resp.data;
               cmd.valid_in = (resp.word_sel == last_word);
            end
         end
      endcase
   end

   // memory side
   always_comb begin
      req.rd   = 1'b0;
      req.wr   = 1'b0;
      req.addr = {cur_tag, cur_index, cnt};
      req.data = stat.data;
      case (state)
         // clean miss starts the fill right away
         st_compare:    req.rd = ~stat.hit & ~victim_dirty;
         st_writeback: begin
            req.wr   = 1'b1;
            req.addr = {stat.tag, cur_index, cnt};
         end
         st_fill_issue: req.rd = 1'b1;
         default: begin
            req.rd = 1'b0;
         end
      endcase
   end

   assign Done     = ((state == st_compare) & stat.hit) | (state == st_done);
   assign err      = (state == st_done);
   assign CacheHit = (state == st_compare) & stat.hit & ~miss_seen;
   assign Stall    = (state != st_idle) & ~Done;
   assign DataOut  = stat.data;

   // every request ends with a single done pulse
   assert property (@(posedge clk) disable iff (reset) Done |=> !Done);

endmodule

// File: cache/cache_store.sv
// direct-mapped cache arrays
`timescale 1ns/1ps

module cache_store (
   input  logic                 clk,
   input  logic                 reset,
   input  mem_pkg::cache_cmd_t  cmd,
   output mem_pkg::cache_stat_t stat
);
   import mem_pkg::*;

   tag_t  tag_mem  [num_lines];
   word_t data_mem [num_lines][words_per_line];
   logic [num_lines-1:0] valid_bits;
   logic [num_lines-1:0] dirty_bits;

   tag_t line_tag;
   logic line_valid;
   logic line_dirty;
   logic tag_match;
   logic line_hit;
   logic hit_write;
   logic fill_write;
   logic fill_last;

   assign line_tag   = tag_mem[cmd.index];
   assign line_valid = valid_bits[cmd.index];
   assign line_dirty = dirty_bits[cmd.index];
   assign tag_match  = (line_tag == cmd.tag);

   // hit only counts in a compare access
   assign line_hit = cmd.enable & cmd.comp & line_valid & tag_match;

   always_comb begin
      stat.hit   = line_hit;
      stat.dirty = line_dirty;
      stat.valid = line_valid;
      stat.tag   = line_tag;
      stat.data  = data_mem[cmd.index][cmd.word_sel];
   end

   // compare writes land only on a hit, access writes always land
   assign hit_write  = cmd.enable & cmd.write & cmd.comp & line_hit;
   assign fill_write = cmd.enable & cmd.write & ~cmd.comp;
   assign fill_last  = fill_write & (cmd.word_sel == word_sel_t'(words_per_line - 1));

   always_ff @(posedge clk) begin
      if (hit_write || fill_write) begin
         data_mem[cmd.index][cmd.word_sel] <= cmd.data;
      end
      // new tag arrives with the last word of a fill
      if (fill_last) begin
         tag_mem[cmd.index] <= cmd.tag;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
         dirty_bits <= '0;
      end else begin
         if (fill_write) begin
            valid_bits[cmd.index] <= cmd.valid_in;
            dirty_bits[cmd.index] <= 1'b0;
         end else if (hit_write) begin
            dirty_bits[cmd.index] <= 1'b1;
         end
      end
   end

   // a line is only validated by an enabled access from the controller
   assert property (@(posedge clk) disable iff (reset)
      (cmd.write && !cmd.comp && cmd.valid_in) |-> cmd.enable);

endmodule

// File: common/mem_pkg.sv
// memory system shared types
package mem_pkg;

   // geometry of the cache and the banked memory
   localparam int unsigned words_per_line = 4;
   localparam int unsigned num_lines = 256;
   localparam int unsigned num_banks = 4;
   localparam int unsigned bank_words = 8192;

   typedef logic [15:0] addr_t;
   typedef logic [15:0] word_t;
   typedef logic [4:0]  tag_t;
   typedef logic [7:0]  index_t;
   typedef logic [1:0]  word_sel_t;

   // word address is tag, index and word select
   typedef logic [14:0] waddr_t;
   // one word inside a single bank
   typedef logic [12:0] row_t;

   typedef struct packed {
      logic   rd;
      logic   wr;
      waddr_t addr;
      word_t  data;
   } mem_req_t;

   typedef struct packed {
      logic      valid;
      word_sel_t word_sel;
      word_t     data;
   } mem_resp_t;

   typedef struct packed {
      logic      enable;
      logic      comp;
      logic      write;
      logic      valid_in;
      index_t    index;
      tag_t      tag;
      word_sel_t word_sel;
      word_t     data;
   } cache_cmd_t;

   typedef struct packed {
      logic  hit;
      logic  dirty;
      logic  valid;
      tag_t  tag;
      word_t data;
   } cache_stat_t;

endpackage

// File: dv/mem_system_tb.sv
// memory system testbench
`timescale 1ns/1ps

module mem_system_tb;
   import mem_pkg::*;

   localparam int unsigned bank_latency = 2;
   localparam int clk_period = 20;
   localparam int max_vec = 64;
   localparam int vec_fields = 5;
   localparam int num_random = 40;
   localparam int done_limit = 40;

   logic  clk;
   logic  reset;
   addr_t addr;
   word_t data_in;
   logic  rd;
   logic  wr;
   word_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   // one vector is op, addr, wdata, expected data, expected hit
   logic [15:0] vec_mem [max_vec * vec_fields];
   int     num_vec;
   logic   loaded;
   int     errors;
   int     requests;
   integer seed;

   // reference model of memory contents and cache tags
   word_t ref_mem [32768];
   tag_t  ref_tag [num_lines];
   logic  ref_valid [num_lines];
   logic  ref_dirty [num_lines];

   // random traffic stays inside these lines
   tag_t   tag_pick [4];
   index_t idx_pick [2];

   mem_system #(
      .bank_latency (bank_latency)
   ) dut_i (
      .clk      (clk),
      .reset    (reset),
      .Addr     (addr),
      .DataIn   (data_in),
      .Rd       (rd),
      .Wr       (wr),
      .DataOut  (data_out),
      .Done     (done),
      .Stall    (stall),
      .CacheHit (cache_hit),
      .err      (err)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   task automatic check_value(input string name, input word_t expected, input word_t actual);
      if (expected !== actual) begin
         $display("mismatch %s expected %h actual %h", name, expected, actual);
         errors++;
      end
   endtask

   // write-back, write-allocate direct-mapped model
   task automatic predict_access(input logic [1:0] op, input addr_t a, input word_t wdata,
                                 output word_t exp_data, output logic exp_hit,
                                 output logic exp_err, output logic victim);
      tag_t   tg;
      index_t idx;
      waddr_t wa;
      tg = a[15:11];
      idx = a[10:3];
      wa = a[15:1];
      exp_err = (op == 2'd2) || a[0];
      exp_hit = 1'b0;
      victim = 1'b0;
      exp_data = '0;
      if (!exp_err) begin
         exp_hit = ref_valid[idx] && (ref_tag[idx] == tg);
         victim = !exp_hit && ref_valid[idx] && ref_dirty[idx];
         if (!exp_hit) begin
            ref_valid[idx] = 1'b1;
            ref_tag[idx] = tg;
            ref_dirty[idx] = 1'b0;
         end
         if (op == 2'd1) begin
            ref_mem[wa] = wdata;
            ref_dirty[idx] = 1'b1;
         end
         exp_data = ref_mem[wa];
      end
   endtask

   // hold the request until Done, then release it
   task automatic drive_request(input string name, input logic [1:0] op, input addr_t a,
                                input word_t wdata, output word_t rdata, output logic hit,
                                output logic bad, output int lat, output logic seen);
      int k;
      k = 0;
      seen = 1'b0;
      rdata = '0;
      hit = 1'b0;
      bad = 1'b0;
      lat = 0;
      @(posedge clk);
      addr <= a;
      data_in <= wdata;
      rd <= (op != 2'd1);
      wr <= (op != 2'd0);
      while (!seen && k < done_limit) begin
         @(negedge clk);
         k++;
         if (done) begin
            seen = 1'b1;
            rdata = data_out;
            hit = cache_hit;
            bad = err;
            lat = k - 1;
            check_value({name, " stall with done"}, 16'(1'b0), 16'(stall));
         end else if (k > 1) begin
            check_value({name, " stall while busy"}, 16'(1'b1), 16'(stall));
         end
      end
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
   endtask

   task automatic run_access(input string name, input logic [1:0] op, input addr_t a,
                             input word_t wdata, input logic from_file,
                             input word_t file_data, input logic file_hit);
      word_t exp_data;
      logic  model_hit;
      logic  exp_hit;
      logic  exp_err;
      logic  victim;
      word_t rdata;
      logic  hit;
      logic  bad;
      logic  seen;
      int    lat;
      int    exp_lat;
      predict_access(op, a, wdata, exp_data, model_hit, exp_err, victim);
      exp_hit = from_file ? file_hit : model_hit;
      if (from_file) begin
         exp_data = file_data;
      end
      drive_request(name, op, a, wdata, rdata, hit, bad, lat, seen);
      requests++;
      if (!seen) begin
         $display("%s: no Done within %0d cycles", name, done_limit);
         errors++;
      end else begin
         check_value({name, " err"}, 16'(exp_err), 16'(bad));
         check_value({name, " hit"}, 16'(exp_hit), 16'(hit));
         if (op == 2'd0 && !exp_err) begin
            check_value({name, " data"}, exp_data, rdata);
         end
         // hit and error finish right away, a miss waits for the whole line
         if (exp_err || model_hit) begin
            exp_lat = 1;
         end else begin
            exp_lat = int'(words_per_line + bank_latency + 1);
         end
         if (victim) begin
            if (lat < exp_lat + int'(words_per_line)) begin
               $display("%s: dirty miss done after %0d cycles, too soon for a write-back",
                        name, lat);
               errors++;
            end
         end else begin
            check_value({name, " latency"}, 16'(exp_lat), 16'(lat));
         end
      end
   endtask

   initial begin
      int          j;
      logic [31:0] r;
      logic [1:0]  op;
      addr_t       a;
      reset = 1'b1;
      addr = '0;
      data_in = '0;
      rd = 1'b0;
      wr = 1'b0;
      errors = 0;
      requests = 0;
      loaded = 1'b0;
      num_vec = 0;
      seed = 32'hce2b;
      tag_pick = '{5'h02, 5'h09, 5'h13, 5'h1e};
      idx_pick = '{8'h40, 8'h41};
      for (int w = 0; w < 32768; w++) begin
         ref_mem[w] = '0;
      end
      for (int n = 0; n < num_lines; n++) begin
         ref_tag[n] = '0;
         ref_valid[n] = 1'b0;
         ref_dirty[n] = 1'b0;
      end
      // unused entries keep the end marker
      for (int v = 0; v < max_vec * vec_fields; v++) begin
         vec_mem[v] = 16'hffff;
      end
      $readmemh("dv/mem_testdata.txt", vec_mem);
      while (num_vec < max_vec && vec_mem[num_vec * vec_fields] != 16'hffff) begin
         num_vec++;
      end
      loaded = 1'b1;

      repeat (4) @(posedge clk);
      reset <= 1'b0;

      for (j = 0; j < num_vec; j++) begin
         run_access($sformatf("vec%0d", j), vec_mem[j * vec_fields][1:0],
                    vec_mem[j * vec_fields + 1], vec_mem[j * vec_fields + 2], 1'b1,
                    vec_mem[j * vec_fields + 3], vec_mem[j * vec_fields + 4][0]);
      end

      // mixed reads and writes fighting over two lines
      for (j = 0; j < num_random; j++) begin
         r = $random(seed);
         op = {1'b0, r[5]};
         a = {tag_pick[r[1:0]], idx_pick[r[2]], r[4:3], 1'b0};
         run_access($sformatf("rand%0d", j), op, a, r[31:16], 1'b0, '0, 1'b0);
      end

      $display("%0d requests checked, %0d errors", requests, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   initial begin
      wait (loaded);
      #((num_vec + num_random) * done_limit * clk_period);
      $display("watchdog: run did not finish in time");
      $display("TEST FAIL");
      $finish;
   end

endmodule

// File: dv/mem_testdata.txt
// op addr wdata expected_data expected_hit, all hex
// op 0 read, 1 write, 2 read and write together
0 0008 0000 0000 0
0 000c 0000 0000 1
1 000a beef 0000 1
0 000a 0000 beef 1
1 1810 1234 0000 0
0 2810 0000 0000 0
0 1810 0000 1234 0
0 1812 0000 0000 1
0 3808 0000 0000 0
0 000a 0000 beef 0
0 000b 0000 0000 0
0 000a 0000 beef 1
2 000a dead 0000 0
0 000a 0000 beef 1
1 1811 5555 0000 0
0 1810 0000 1234 1
1 4020 00a5 0000 0
0 4026 0000 0000 1
0 4020 0000 00a5 1
1 4024 7777 0000 1
0 4024 0000 7777 1

// File: list.f
common/mem_pkg.sv
cache/cache_store.sv
cache/cache_controller.sv
bank_memory/bank_memory.sv
source/mem_system.sv
dv/mem_system_tb.sv

// File: source/mem_system.sv
// cached memory system top
`timescale 1ns/1ps

module mem_system #(
   parameter int unsigned bank_latency = 2
) (
   input  logic           clk,
   input  logic           reset,
   input  mem_pkg::addr_t Addr,
   input  mem_pkg::word_t DataIn,
   input  logic           Rd,
   input  logic           Wr,
   output mem_pkg::word_t DataOut,
   output logic           Done,
   output logic           Stall,
   output logic           CacheHit,
   output logic           err
);
   import mem_pkg::*;

   cache_cmd_t  cache_cmd;
   cache_stat_t cache_stat;
   mem_req_t    mem_req;
   mem_resp_t   mem_resp;
   logic        mem_stall;
   logic        ctrl_err;
   logic        mem_err;

   cache_store store_i (
      .clk   (clk),
      .reset (reset),
      .cmd   (cache_cmd),
      .stat  (cache_stat)
   );

   bank_memory #(
      .bank_latency (bank_latency)
   ) memory_i (
      .clk       (clk),
      .reset     (reset),
      .req       (mem_req),
      .resp      (mem_resp),
      .mem_stall (mem_stall),
      .err       (mem_err)
   );

   cache_controller ctrl_i (
      .clk       (clk),
      .reset     (reset),
      .Addr      (Addr),
      .DataIn    (DataIn),
      .Rd        (Rd),
      .Wr        (Wr),
      .stat      (cache_stat),
      .resp      (mem_resp),
      .mem_stall (mem_stall),
      .cmd       (cache_cmd),
      .req       (mem_req),
      .DataOut   (DataOut),
      .Done      (Done),
      .Stall     (Stall),
      .CacheHit  (CacheHit),
      .err       (ctrl_err)
   );

   assign err = ctrl_err | mem_err;

endmodule
